//--- hw/coeff_pkg.sv
package coeff_pkg;

        // ###########################################################################
        // row word geometry
        // ###########################################################################

        localparam int COEF_W   = 16;
        localparam int LANES    = 16;                   // coefficients per row word
        localparam int MAX_ROWS = 64;                   // rows of a 32x32 block
        localparam int IDX_W    = 6;                    // memory row index

        typedef logic signed [COEF_W-1:0] coef_t;

        typedef logic [1:0] tq_size_t;                  // 0:4x4 1:8x8 2:16x16 3:32x32

        // memory port uses flat, datapaths use lane
        typedef union packed {
                logic [LANES*COEF_W-1:0] flat;
                coef_t [LANES-1:0]       lane;          // lane 0 in low bits
        } coef_row_u;

        // ###########################################################################
        // rows per block size
        // ###########################################################################

        function automatic int rows_of(input tq_size_t size);
                return 1 << (2 * int'(size));           // 1, 4, 16, 64
        endfunction

endpackage

//--- hw/quant_pkg.sv
package quant_pkg;

        // ###########################################################################
        // qp and scaling
        // ###########################################################################

        typedef logic [5:0] qp_t;                       // legal 0..51

        // forward scale, indexed by qp % 6
        localparam int Q_SCALE [6] =
                '{26214, 23302, 20560, 18396, 16384, 14564};

        // inverse scale, indexed by qp % 6
        localparam int DQ_SCALE [6] =
                '{40, 45, 51, 57, 64, 72};

        localparam int QBITS_BASE = 14;                 // plus qp / 6
        localparam int DQ_SHIFT   = 6;

        // ###########################################################################
        // qp split into period and remainder
        // ###########################################################################

        function automatic void qp_split(input qp_t qp, output logic [3:0] per,
                                         output logic [2:0] rem);
                per = 4'(qp / 6);
                rem = 3'(qp % 6);
        endfunction

endpackage

//--- hw/fwd_quantizer.sv
`timescale 1ns/1ps

module fwd_quantizer #(
        parameter int INTRA_OFFSET = 171,
        parameter int INTER_OFFSET = 85
) (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 i_valid,
        input  coeff_pkg::coef_row_u i_row,
        input  quant_pkg::qp_t       i_qp,
        input  logic                 i_intra,
        output logic                 o_valid,
        output coeff_pkg::coef_row_u o_row
);

        import coeff_pkg::*;
        import quant_pkg::*;

        localparam int OFFS_FRAC = 9;                   // offsets in 1/512

        logic [3:0]       qp_per;
        logic [2:0]       qp_rem;
        logic [COEF_W:0]  mag [LANES];

        logic             s1_valid;
        logic [31:0]      s1_prod [LANES];
        logic [LANES-1:0] s1_neg;
        logic [4:0]       s1_qbits;

        logic [31:0]      offs;
        logic [31:0]      rnd_add;
        logic [31:0]      lvl [LANES];
        logic [31:0]      sat [LANES];
        coef_row_u        q_next;

        // ###########################################################################
        // stage 1 magnitude times scale
        // ###########################################################################

        always_comb
        begin
                qp_split(i_qp, qp_per, qp_rem);
                for (int i = 0; i < LANES; i++)
                begin
                        if (i_row.lane[i][COEF_W-1])
                                mag[i] = ~{1'b1, i_row.lane[i]} + 1'b1;  // -32768 -> 32768
                        else
                                mag[i] = {1'b0, i_row.lane[i]};
                end
        end

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        s1_valid <= 1'b0;
                else
                        s1_valid <= i_valid;
        end

        always_ff @(posedge clk)
        begin
                if (i_valid)
                begin
                        for (int i = 0; i < LANES; i++)
                        begin
                                s1_prod[i] <= 32'(mag[i]) * 32'(Q_SCALE[qp_rem]);
                                s1_neg[i]  <= i_row.lane[i][COEF_W-1];
                        end
                        s1_qbits <= 5'(QBITS_BASE + int'(qp_per));
                end
        end

        // ###########################################################################
        // stage 2 round, shift, sign, saturate
        // ###########################################################################

        always_comb
        begin
                offs    = i_intra ? 32'(INTRA_OFFSET) : 32'(INTER_OFFSET);
                rnd_add = offs << (s1_qbits - 5'(OFFS_FRAC));
                for (int i = 0; i < LANES; i++)
                begin
                        lvl[i] = (s1_prod[i] + rnd_add) >> s1_qbits;
                        if (s1_neg[i])
                                sat[i] = (lvl[i] > 32'd32768) ? 32'hffff_8000 : 32'd0 - lvl[i];
                        else
                                sat[i] = (lvl[i] > 32'd32767) ? 32'd32767 : lvl[i];
                        q_next.lane[i] = sat[i][COEF_W-1:0];
                end
        end

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        o_valid <= 1'b0;
                else
                        o_valid <= s1_valid;
        end

        always_ff @(posedge clk)
        begin
                if (s1_valid)
                        o_row <= q_next;
        end

endmodule

//--- hw/coef_row_sequencer.sv
`timescale 1ns/1ps

module coef_row_sequencer (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        i_wen,
        input  coeff_pkg::tq_size_t         i_tq_size,
        output logic [coeff_pkg::IDX_W-1:0] o_widx,
        output logic                        o_ren,
        output logic [coeff_pkg::IDX_W-1:0] o_ridx,
        output logic                        o_rd_valid
);

        import coeff_pkg::*;

        logic [IDX_W-1:0] wcnt;
        logic [IDX_W-1:0] rcnt;
        logic [IDX_W-1:0] last_row;
        logic [IDX_W:0]   stride;                       // 64 needs the extra bit

        // ###########################################################################
        // index striding
        // ###########################################################################

        assign last_row = IDX_W'(rows_of(i_tq_size) - 1);
        assign stride   = (IDX_W+1)'(MAX_ROWS / rows_of(i_tq_size));
        assign o_widx   = IDX_W'(wcnt * stride);
        assign o_ridx   = IDX_W'(rcnt * stride);

        // ###########################################################################
        // row counters and read enable
        // ###########################################################################

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        wcnt <= '0;
                else if (i_wen)
                        wcnt <= wcnt + 1'b1;
                else
                        wcnt <= '0;
        end

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        rcnt <= '0;
                else if (o_ren)
                        rcnt <= rcnt + 1'b1;
                else
                        rcnt <= '0;
        end

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        o_ren <= 1'b0;
                else if (i_wen)
                        o_ren <= (wcnt == last_row);    // read-back after last write
                else if (o_ren && rcnt == last_row)
                        o_ren <= 1'b0;
        end

        // memory answers one cycle after the strobe
        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        o_rd_valid <= 1'b0;
                else
                        o_rd_valid <= o_ren;
        end

endmodule

//--- hw/inv_dequantizer.sv
`timescale 1ns/1ps

module inv_dequantizer (
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 i_rd_valid,
        input  coeff_pkg::coef_row_u i_cef_data,
        input  quant_pkg::qp_t       i_qp,
        output logic                 o_valid,
        output coeff_pkg::coef_row_u o_row
);

        import coeff_pkg::*;
        import quant_pkg::*;

        localparam int DQ_RND = 1 << (DQ_SHIFT - 1);    // 32

        logic               cap_valid;
        coef_row_u          cap;
        logic [3:0]         qp_per;
        logic [2:0]         qp_rem;
        logic               s1_valid;
        logic signed [31:0] s1_scaled [LANES];
        logic signed [31:0] rec [LANES];
        coef_row_u          dq_next;

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                begin
                        cap_valid <= 1'b0;
                        s1_valid  <= 1'b0;
                        o_valid   <= 1'b0;
                end
                else
                begin
                        cap_valid <= i_rd_valid;
                        s1_valid  <= cap_valid;
                        o_valid   <= s1_valid;
                end
        end

        always_ff @(posedge clk)
        begin
                if (i_rd_valid)
                        cap <= i_cef_data;              // capture memory word
        end

        // ###########################################################################
        // scale, round and clamp
        // ###########################################################################

        always_comb
        begin
                qp_split(i_qp, qp_per, qp_rem);
        end

        always_ff @(posedge clk)
        begin
                if (cap_valid)
                begin
                        for (int i = 0; i < LANES; i++)
                                s1_scaled[i] <= (32'($signed(cap.lane[i])) * DQ_SCALE[qp_rem])
                                                <<< qp_per;
                end
        end

        always_comb
        begin
                for (int i = 0; i < LANES; i++)
                begin
                        rec[i] = (s1_scaled[i] + DQ_RND) >>> DQ_SHIFT;   // floor on negatives
                        if (rec[i] > 32'sd32767)
                                dq_next.lane[i] = 16'sh7fff;
                        else if (rec[i] < -32'sd32768)
                                dq_next.lane[i] = 16'sh8000;
                        else
                                dq_next.lane[i] = rec[i][COEF_W-1:0];
                end
        end

        always_ff @(posedge clk)
        begin
                if (s1_valid)
                        o_row <= dq_next;
        end

endmodule

//--- hw/quant_recon_top.sv
`timescale 1ns/1ps

module quant_recon_top #(
        parameter int INTRA_OFFSET = 171,
        parameter int INTER_OFFSET = 85
) (
        input  logic                        clk,
        input  logic                        rst,
        input  logic                        i_valid,
        input  coeff_pkg::coef_row_u        i_row,
        input  quant_pkg::qp_t              i_qp,
        input  logic                        i_intra,
        input  coeff_pkg::tq_size_t         i_tq_size,
        input  coeff_pkg::coef_row_u        i_cef_data,
        output logic                        o_cef_wen,
        output logic [coeff_pkg::IDX_W-1:0] o_cef_widx,
        output coeff_pkg::coef_row_u        o_cef_data,
        output logic                        o_cef_ren,
        output logic [coeff_pkg::IDX_W-1:0] o_cef_ridx,
        output logic                        o_valid,
        output coeff_pkg::coef_row_u        o_row
);

        import coeff_pkg::*;

        logic      q_valid;
        coef_row_u q_row;
        logic      rd_valid;

        assign o_cef_wen       = q_valid;
        assign o_cef_data.flat = q_row.flat;            // memory sees the flat word

        fwd_quantizer #(
                .INTRA_OFFSET (INTRA_OFFSET),
                .INTER_OFFSET (INTER_OFFSET)
        ) u_fwd (
                .clk     (clk),
                .rst     (rst),
                .i_valid (i_valid),
                .i_row   (i_row),
                .i_qp    (i_qp),
                .i_intra (i_intra),
                .o_valid (q_valid),
                .o_row   (q_row)
        );

        coef_row_sequencer u_seq (
                .clk        (clk),
                .rst        (rst),
                .i_wen      (q_valid),
                .i_tq_size  (i_tq_size),
                .o_widx     (o_cef_widx),
                .o_ren      (o_cef_ren),
                .o_ridx     (o_cef_ridx),
                .o_rd_valid (rd_valid)
        );

        inv_dequantizer u_inv (
                .clk        (clk),
                .rst        (rst),
                .i_rd_valid (rd_valid),
                .i_cef_data (i_cef_data),
                .i_qp       (i_qp),
                .o_valid    (o_valid),
                .o_row      (o_row)
        );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
        parameter int PERIOD_NS  = 4,
        parameter int RST_CYCLES = 3
) (
        output logic o_clk,
        output logic o_rst
);

        initial
        begin
                o_clk = 1'b0;
                forever #(PERIOD_NS / 2) o_clk = ~o_clk;
        end

        initial
        begin
                o_rst = 1'b0;                           // active low
                repeat (RST_CYCLES) @(posedge o_clk);
                #1 o_rst = 1'b1;
        end

endmodule

//--- verification/quant_recon_sva.sv
`timescale 1ns/1ps

module quant_recon_sva (
        input  logic clk,
        input  logic rst,
        input  logic i_wen,
        input  logic i_ren,
        input  logic i_valid
);

        int fail_cnt = 0;

        a_no_overlap: assert property (@(posedge clk) disable iff (!rst) !(i_wen && i_ren))
        else
        begin
                fail_cnt++;
                $error("memory write and read strobes high together");
        end

        // read strobe to reconstructed row is a fixed pipe
        a_read_latency: assert property (@(posedge clk) disable iff (!rst) i_ren |-> ##4 i_valid)
        else
        begin
                fail_cnt++;
                $error("no output row 4 cycles after a memory read");
        end

        a_reset_quiet: assert property (@(posedge clk) !rst |-> !i_valid)
        else
        begin
                fail_cnt++;
                $error("output valid high while in reset");
        end

endmodule

bind quant_recon_top quant_recon_sva u_sva (
        .clk     (clk),
        .rst     (rst),
        .i_wen   (o_cef_wen),
        .i_ren   (o_cef_ren),
        .i_valid (o_valid)
);

//--- verification/tb_quant_recon.sv
`timescale 1ns/1ps

module tb_quant_recon;

        import coeff_pkg::*;

        localparam int INTRA_OFS   = 171;
        localparam int INTER_OFS   = 85;
        localparam int N_RAND      = 24;
        localparam int N_EDGE      = 6;
        localparam int EDGE_QP [3] = '{0, 48, 51};
        localparam int BLK_CYC     = 2 * MAX_ROWS + 32;  // fill, read-back and pipe slack
        localparam int WD_NS       = ((N_RAND + N_EDGE) * BLK_CYC + 200) * 4;
        localparam int Q_TAB [6]   = '{26214, 23302, 20560, 18396, 16384, 14564};
        localparam int DQ_TAB [6]  = '{40, 45, 51, 57, 64, 72};

        logic             clk;
        logic             rst;
        logic             i_valid;
        coef_row_u        i_row;
        logic [5:0]       i_qp;
        logic             i_intra;
        logic [1:0]       i_tq_size;
        coef_row_u        i_cef_data = '0;
        logic             o_cef_wen;
        logic [IDX_W-1:0] o_cef_widx;
        coef_row_u        o_cef_data;
        logic             o_cef_ren;
        logic [IDX_W-1:0] o_cef_ridx;
        logic             o_valid;
        coef_row_u        o_row;

        coef_row_u        mem [MAX_ROWS];
        coef_row_u        rd_word = '0;
        coef_row_u        exp_wr [$];
        coef_row_u        exp_out [$];
        int               exp_widx [$];
        int               exp_ridx [$];
        int               cur_rows = 0;
        int               ren_run = 0;
        int               n_checks = 0;
        int               n_err = 0;
        int               n_tests = 0;
        logic [31:0]      seed = 32'h84c2;

        clk_gen u_clk (
                .o_clk (clk),
                .o_rst (rst)
        );

        quant_recon_top #(
                .INTRA_OFFSET (INTRA_OFS),
                .INTER_OFFSET (INTER_OFS)
        ) DUT (
                .clk        (clk),
                .rst        (rst),
                .i_valid    (i_valid),
                .i_row      (i_row),
                .i_qp       (i_qp),
                .i_intra    (i_intra),
                .i_tq_size  (i_tq_size),
                .i_cef_data (i_cef_data),
                .o_cef_wen  (o_cef_wen),
                .o_cef_widx (o_cef_widx),
                .o_cef_data (o_cef_data),
                .o_cef_ren  (o_cef_ren),
                .o_cef_ridx (o_cef_ridx),
                .o_valid    (o_valid),
                .o_row      (o_row)
        );

        // ###########################################################################
        // reference model
        // ###########################################################################

        function automatic logic [31:0] next_rand();
                seed = seed * 32'd1664525 + 32'd1013904223;
                return seed;
        endfunction

        function automatic logic signed [15:0] quant_ref(input logic signed [15:0] c,
                                                         input int qp, input bit intra);
                longint mag;
                longint ofs;
                longint lvl;
                int     qbits;
                mag   = (c < 0) ? -longint'(c) : longint'(c);
                qbits = 14 + qp / 6;
                ofs   = intra ? INTRA_OFS : INTER_OFS;
                lvl   = (mag * Q_TAB[qp % 6] + (ofs << (qbits - 9))) >> qbits;
                if (c < 0)
                        return (lvl >= 32768) ? 16'sh8000 : 16'(-lvl);
                return (lvl > 32767) ? 16'sh7fff : 16'(lvl);
        endfunction

        function automatic logic signed [15:0] dequant_ref(input logic signed [15:0] l,
                                                           input int qp);
                longint v;
                v = (longint'(l) * DQ_TAB[qp % 6]) <<< (qp / 6);
                v = (v + 64'sd32) >>> 6;                // floor on negatives
                if (v > 32767)
                        return 16'sh7fff;
                if (v < -32768)
                        return 16'sh8000;
                return 16'(v);
        endfunction

        task automatic check_val(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
                n_checks++;
                if (got !== exp)
                begin
                        n_err++;
                        $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
                end
        endtask

        task automatic flag_error(input string msg);
                n_err++;
                $display("ERROR %s", msg);
        endtask

        task automatic end_test(input string name, input int err0);
                n_tests++;
                $display("test %-14s %s (%0d errors)", name,
                         (n_err == err0) ? "passed" : "failed", n_err - err0);
        endtask

        // ###########################################################################
        // coefficient memory and output monitor
        // ###########################################################################

        always @(posedge clk)
        begin
                #1;
                i_cef_data = rd_word;                   // data one cycle after the read
        end

        always @(negedge clk)
        begin
                coef_row_u w;
                if (rst)
                begin
                        if (o_cef_wen)
                        begin
                                mem[o_cef_widx] = o_cef_data;
                                if (exp_wr.size() == 0)
                                        flag_error("memory write with no row pending");
                                else
                                begin
                                        w = exp_wr.pop_front();
                                        check_val("o_cef_data", o_cef_data.flat, w.flat);
                                        check_val("o_cef_widx", 256'(o_cef_widx),
                                                  256'(exp_widx.pop_front()));
                                end
                        end
                        if (o_cef_ren)
                        begin
                                rd_word = mem[o_cef_ridx];
                                ren_run++;
                                if (exp_wr.size() != 0)
                                        flag_error("read-back began before the last write");
                                if (exp_ridx.size() == 0)
                                        flag_error("memory read with no row pending");
                                else
                                        check_val("o_cef_ridx", 256'(o_cef_ridx),
                                                  256'(exp_ridx.pop_front()));
                        end
                        else if (ren_run != 0)
                        begin
                                check_val("o_cef_ren length", 256'(ren_run), 256'(cur_rows));
                                ren_run = 0;
                        end
                        if (o_valid)
                        begin
                                if (exp_out.size() == 0)
                                        flag_error("output row with none expected");
                                else
                                begin
                                        w = exp_out.pop_front();
                                        check_val("o_row", o_row.flat, w.flat);
                                end
                        end
                end
        end

        // ###########################################################################
        // stimulus
        // ###########################################################################

        task automatic run_block(input int qp, input bit intra, input int size,
                                 input bit edge_rows);
                coef_row_u   in_row;
                coef_row_u   q_row;
                coef_row_u   r_row;
                logic [31:0] r;
                int          n;
                int          k;
                n        = 1 << (2 * size);
                cur_rows = n;
                for (int row = 0; row < n; row++)
                begin
                        for (int ln = 0; ln < LANES; ln++)
                        begin
                                r = next_rand();
                                k = (ln + row) % 3;
                                if (edge_rows)
                                        in_row.lane[ln] = (k == 0) ? 16'sh7fff :
                                                          (k == 1) ? -16'sh7fff : 16'sh8000;
                                else if (r[0])
                                        in_row.lane[ln] = r[31:16];
                                else
                                        in_row.lane[ln] = $signed(r[31:16]) >>> 7;  // small
                                q_row.lane[ln] = quant_ref(in_row.lane[ln], qp, intra);
                                r_row.lane[ln] = dequant_ref(q_row.lane[ln], qp);
                        end
                        exp_wr.push_back(q_row);
                        exp_out.push_back(r_row);
                        exp_widx.push_back(row * (MAX_ROWS / n));
                        exp_ridx.push_back(row * (MAX_ROWS / n));
                        @(posedge clk);
                        #1;
                        i_valid   = 1'b1;
                        i_row     = in_row;
                        i_qp      = 6'(qp);
                        i_intra   = intra;
                        i_tq_size = 2'(size);
                end
                @(posedge clk);
                #1;
                i_valid = 1'b0;
                while (exp_out.size() != 0)
                        @(posedge clk);                 // hold qp until the last row is out
        endtask

        initial
        begin
                int          err0;
                logic [31:0] rnd;
                i_valid   = 1'b0;
                i_row     = '0;
                i_qp      = '0;
                i_intra   = 1'b0;
                i_tq_size = '0;
                @(posedge rst);
                err0 = n_err;
                repeat (8)
                begin
                        @(negedge clk);
                        check_val("o_cef_wen", 256'(o_cef_wen), 256'(0));
                        check_val("o_cef_ren", 256'(o_cef_ren), 256'(0));
                        check_val("o_valid", 256'(o_valid), 256'(0));
                end
                end_test("reset idle", err0);

                err0 = n_err;
                for (int b = 0; b < N_RAND; b++)
                begin
                        rnd = next_rand();
                        run_block(int'(rnd % 32'd52), rnd[20], b % 4, 1'b0);
                end
                end_test("random blocks", err0);

                err0 = n_err;
                for (int q = 0; q < 3; q++)
                begin
                        run_block(EDGE_QP[q], 1'b0, 1, 1'b1);
                        run_block(EDGE_QP[q], 1'b1, 1, 1'b1);
                end
                end_test("edge values", err0);

                n_err += DUT.u_sva.fail_cnt;
                $display("tests: %0d  checks: %0d  errors: %0d", n_tests, n_checks, n_err);
                if (n_err == 0)
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        end

        initial
        begin
                #(WD_NS);
                $display("TIMEOUT: run did not finish within %0d ns", WD_NS);
                $display("Something failed");
                $finish;
        end

endmodule

//--- build.f
hw/coeff_pkg.sv
hw/quant_pkg.sv
hw/fwd_quantizer.sv
hw/coef_row_sequencer.sv
hw/inv_dequantizer.sv
hw/quant_recon_top.sv
verification/clk_gen.sv
verification/quant_recon_sva.sv
verification/tb_quant_recon.sv

//--- run_sim.sh
#!/bin/sh
# build and run the quant_recon testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_quant_recon -f build.f -o Vtb_quant_recon
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

# keep running after an assertion error so the testbench can count it
./obj_dir/Vtb_quant_recon +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "Something failed" "$LOG"; then
        echo "simulation reported failure"
        exit 1
fi
echo "simulation passed"
exit 0
